// File: verilog/memMapPkg.sv
package memMapPkg;

    ////////////////////////////////////////////////////////////
    // Board address map
    ////////////////////////////////////////////////////////////

    // Everything below this goes to Ram1, the rest to Ram2
    localparam logic [15:0] RAM1_UPPER = 16'h8000;

    // Serial port registers, both on the Ram1 data bus
    localparam logic [15:0] COM1_DATA = 16'hBF00;
    localparam logic [15:0] COM1_COMMAND = 16'hBF01;

    ////////////////////////////////////////////////////////////
    // Fixed instruction words
    ////////////////////////////////////////////////////////////

    // Shown to the decoder while Ram1 is taken by a data access
    localparam logic [15:0] NOP_INSTRUCT = 16'h0800;

endpackage

// File: verilog/busPkg.sv
package busPkg;

    ////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////

    // Data and instruction words share one width
    typedef logic [15:0] word_t;

    // SRAM address pins, top two bits tied low on this board
    typedef logic [17:0] sramAddr_t;

    // What a CPU data access targets
    typedef enum logic [2:0] {
        accNone,
        accRam1,
        accRam2,
        accUartData,
        accUartStatus
    } accessKind_t;

    ////////////////////////////////////////////////////////////
    // Transmit queue
    ////////////////////////////////////////////////////////////

    localparam int TX_DEPTH = 4;

endpackage

// File: verilog/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic          clk,
    input  logic          rst,
    input  busPkg::word_t pc,
    input  busPkg::word_t address,
    input  busPkg::word_t writeData,
    input  logic          memRead,
    input  logic          memWrite,
    input  logic          ram1Done,
    input  logic          ram2Done,
    input  logic          uartReadDone,
    input  busPkg::word_t ram1Rdata,
    input  busPkg::word_t ram2Rdata,
    input  logic [7:0]    rxByte,
    input  logic          txFull,
    input  logic          dataReady,
    output logic          stall,
    output logic          memConflict,
    output busPkg::word_t readData,
    output busPkg::word_t instruct,
    output logic          ram1Start,
    output logic          ram1Write,
    output logic          ram2Start,
    output logic          ram2Write,
    output logic          txPush,
    output logic          uartReadReq,
    output busPkg::word_t ram1Addr,
    output busPkg::word_t ram2Addr,
    output busPkg::word_t ram1Wdata,
    output busPkg::word_t ram2Wdata,
    output logic [7:0]    txData
);
    import busPkg::*;
    import memMapPkg::*;

    typedef enum logic [1:0] {
        sIdle,
        sData,
        sUartRd
    } arbState_t;

    arbState_t   state;
    accessKind_t kind;
    accessKind_t kindReg;
    word_t       instrReg;
    logic        reqLive;
    logic        justDone;
    logic        ram1Pending;
    logic        fetchPending;
    logic        dataStart1;
    logic        fetchStart;
    logic        statusRd;
    logic        finish;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        kind = accNone;
        if (memRead || memWrite) begin
            if (address < RAM1_UPPER) begin
                kind = accRam1;
            end else if (address == COM1_DATA) begin
                kind = accUartData;
            end else if (address == COM1_COMMAND) begin
                kind = accUartStatus;
            end else begin
                kind = accRam2;
            end
        end
    end

    // The CPU still holds the old request during the cycle after completion
    assign reqLive = (kind != accNone) && !justDone;

    assign memConflict = reqLive && (kind == accRam1 || kind == accUartData ||
                                     kind == accUartStatus);

    ////////////////////////////////////////////////////////////
    // Start pulses
    ////////////////////////////////////////////////////////////

    assign dataStart1  = (state == sIdle) && reqLive && (kind == accRam1) && !ram1Pending;
    assign ram2Start   = (state == sIdle) && reqLive && (kind == accRam2);
    assign uartReadReq = (state == sIdle) && reqLive && (kind == accUartData) &&
                         memRead && !ram1Pending;
    assign txPush      = (state == sIdle) && reqLive && (kind == accUartData) &&
                         memWrite && !memRead && !txFull;
    assign statusRd    = (state == sIdle) && reqLive && (kind == accUartStatus);

    // Fetch runs whenever Ram1 is free and no data access claims the bus
    assign fetchStart = !ram1Pending && !memConflict && (state != sUartRd);
    assign ram1Start  = dataStart1 || fetchStart;

    assign ram1Write = dataStart1 && memWrite;
    assign ram1Addr  = dataStart1 ? address : pc;
    assign ram1Wdata = writeData;
    assign ram2Write = memWrite;
    assign ram2Addr  = address;
    assign ram2Wdata = writeData;
    assign txData    = writeData[7:0];

    // Completion of the held request
    always_comb begin
        finish = txPush || statusRd;
        if (state == sData) begin
            finish = (kindReg == accRam1) ? ram1Done : ram2Done;
        end else if (state == sUartRd) begin
            finish = uartReadDone;
        end
    end

    assign stall    = reqLive && !finish;
    assign instruct = memConflict ? NOP_INSTRUCT : instrReg;

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= sIdle;
            kindReg      <= accNone;
            justDone     <= 1'b0;
            ram1Pending  <= 1'b0;
            fetchPending <= 1'b0;
            instrReg     <= NOP_INSTRUCT;
        end else begin
            justDone     <= reqLive && finish;
            ram1Pending  <= ram1Start;
            fetchPending <= fetchStart;
            if (fetchPending && ram1Done) begin
                instrReg <= ram1Rdata;
            end
            case (state)
                sIdle: begin
                    if (dataStart1 || ram2Start) begin
                        state   <= sData;
                        kindReg <= kind;
                    end else if (uartReadReq) begin
                        state <= sUartRd;
                    end
                end
                sData: begin
                    if (finish) begin
                        state <= sIdle;
                    end
                end
                default: begin
                    if (uartReadDone) begin
                        state <= sIdle;
                    end
                end
            endcase
        end
    end

    // Read result held until the next completed read
    always_ff @(posedge clk) begin
        if (reqLive && finish && memRead) begin
            case (kind)
                accRam1:       readData <= ram1Rdata;
                accUartData:   readData <= {8'h00, rxByte};
                accUartStatus: readData <= {14'b0, dataReady, !txFull};
                default:       readData <= ram2Rdata;
            endcase
        end
    end

    // Fetch and data may not share the single Ram1 slot
    assert property (@(posedge clk) disable iff (!rst) ram1Done |-> !ram1Start);

endmodule

// File: verilog/sramPort.sv
`timescale 1ns/1ps

module sramPort (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              write,
    input  busPkg::word_t     addr,
    input  busPkg::word_t     wdata,
    input  busPkg::word_t     busIn,
    output logic              done,
    output busPkg::word_t     rdata,
    output busPkg::sramAddr_t sramAddr,
    output logic              sramEN,
    output logic              sramOE,
    output logic              sramWE,
    output busPkg::word_t     busOut,
    output logic              busDrive
);
    import busPkg::*;

    logic      active;
    logic      isWrite;
    sramAddr_t addrReg;
    word_t     dataReg;

    always_ff @(posedge clk) begin
        if (!rst) begin
            active   <= 1'b0;
            isWrite  <= 1'b0;
            sramEN   <= 1'b1;
            sramOE   <= 1'b1;
            sramWE   <= 1'b1;
            busDrive <= 1'b0;
        end else if (start) begin
            // Phase one selects the chip with OE or WE low
            active   <= 1'b1;
            isWrite  <= write;
            sramEN   <= 1'b0;
            sramOE   <= write;
            sramWE   <= !write;
            busDrive <= write;
        end else begin
            // Phase two ends here with all strobes back high
            active <= 1'b0;
            sramEN <= 1'b1;
            sramOE <= 1'b1;
            sramWE <= 1'b1;
            // Write data stays on the bus one cycle past the WE rising edge
            busDrive <= active && isWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addrReg <= {2'b00, addr};
            dataReg <= wdata;
        end
    end

    assign done     = active;
    // Caller latches the SRAM output at the end of phase two
    assign rdata    = busIn;
    assign sramAddr = addrReg;
    assign busOut   = dataReg;

    // A new start never cuts phase two short
    assert property (@(posedge clk) disable iff (!rst) active |-> !start);

endmodule

// File: verilog/txFifo.sv
`timescale 1ns/1ps

module txFifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic       pop,
    input  logic [7:0] pushData,
    output logic [7:0] popData,
    output logic       full,
    output logic       notEmpty
);
    import busPkg::*;

    localparam int PTR_W = $clog2(TX_DEPTH);

    logic [7:0]       mem [TX_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    assign popData  = mem[rdPtr];
    assign full     = (count == (PTR_W+1)'(TX_DEPTH));
    assign notEmpty = (count != '0);

    assert property (@(posedge clk) disable iff (!rst) full |-> !push);
    assert property (@(posedge clk) disable iff (!rst) !notEmpty |-> !pop);

endmodule

// File: verilog/uartPort.sv
`timescale 1ns/1ps

module uartPort (
    input  logic          clk,
    input  logic          rst,
    input  logic          readReq,
    input  logic          notEmpty,
    input  logic          tbre,
    input  logic          tsre,
    input  logic          dataReady,
    input  logic [7:0]    popData,
    input  busPkg::word_t busIn,
    output logic          readDone,
    output logic [7:0]    rxByte,
    output logic          pop,
    output logic          rdn,
    output logic          wrn,
    output busPkg::word_t busOut,
    output logic          busDrive
);
    typedef enum logic [2:0] {
        uIdle,
        uRead,
        uWrite,
        uWaitTbre,
        uWaitTsre
    } uartState_t;

    uartState_t state;
    logic       pendRead;
    logic       rdCnt;

    ////////////////////////////////////////////////////////////
    // Strobe sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= uIdle;
            pendRead <= 1'b0;
            rdCnt    <= 1'b0;
            readDone <= 1'b0;
        end else begin
            readDone <= 1'b0;
            if (readReq) begin
                pendRead <= 1'b1;
            end
            case (state)
                uIdle: begin
                    // A waiting read blocks new transmits
                    if (pendRead) begin
                        if (dataReady) begin
                            state    <= uRead;
                            rdCnt    <= 1'b0;
                            pendRead <= 1'b0;
                        end
                    end else if (notEmpty) begin
                        state <= uWrite;
                    end
                end
                uRead: begin
                    rdCnt <= 1'b1;
                    if (rdCnt) begin
                        state    <= uIdle;
                        readDone <= 1'b1;
                    end
                end
                uWrite:    state <= uWaitTbre;
                uWaitTbre: if (tbre) state <= uWaitTsre;
                default:   if (tsre) state <= uIdle;
            endcase
        end
    end

    // Byte latched as rdn returns high
    always_ff @(posedge clk) begin
        if (state == uRead && rdCnt) begin
            rxByte <= busIn[7:0];
        end
    end

    assign rdn      = (state != uRead);
    assign wrn      = (state != uWrite);
    assign pop      = (state == uWaitTsre) && tsre;
    assign busOut   = {8'h00, popData};
    // Held past the wrn pulse until the chip has taken the byte
    assign busDrive = (state == uWrite) || (state == uWaitTbre);

    // One read outstanding at a time
    assert property (@(posedge clk) disable iff (!rst)
                     readReq |-> !pendRead && (state != uRead));

endmodule

// File: verilog/memorySubsystem.sv
`timescale 1ns/1ps

module memorySubsystem (
    input  logic              clk,
    input  logic              rst,
    input  busPkg::word_t     pc,
    input  busPkg::word_t     address,
    input  busPkg::word_t     writeData,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic              dataReady,
    input  logic              tbre,
    input  logic              tsre,
    output logic              stall,
    output logic              memConflict,
    output busPkg::word_t     readData,
    output busPkg::word_t     instruct,
    output busPkg::sramAddr_t ram1Addr,
    output logic              ram1EN,
    output logic              ram1OE,
    output logic              ram1WE,
    output busPkg::sramAddr_t ram2Addr,
    output logic              ram2EN,
    output logic              ram2OE,
    output logic              ram2WE,
    output logic              rdn,
    output logic              wrn,
    inout  wire [15:0]        ram1Data,
    inout  wire [15:0]        ram2Data
);
    import busPkg::*;

    logic       ram1Start, ram1Write, ram1Done, ram1Drive, ram1OeInt;
    logic       ram2Start, ram2Write, ram2Done, ram2Drive;
    word_t      ram1AddrW, ram1Wdata, ram1Rdata, ram1Out;
    word_t      ram2AddrW, ram2Wdata, ram2Rdata, ram2Out;
    logic       txPush, txPop, txFull, txNotEmpty;
    logic [7:0] txData, txHead, rxByte;
    logic       uartReadReq, uartReadDone, uartDrive;
    word_t      uartOut;

    memArbiter uArbiter (
        .clk(clk), .rst(rst), .pc(pc), .address(address), .writeData(writeData),
        .memRead(memRead), .memWrite(memWrite), .ram1Done(ram1Done),
        .ram2Done(ram2Done), .uartReadDone(uartReadDone), .ram1Rdata(ram1Rdata),
        .ram2Rdata(ram2Rdata), .rxByte(rxByte), .txFull(txFull),
        .dataReady(dataReady), .stall(stall), .memConflict(memConflict),
        .readData(readData), .instruct(instruct), .ram1Start(ram1Start),
        .ram1Write(ram1Write), .ram2Start(ram2Start), .ram2Write(ram2Write),
        .txPush(txPush), .uartReadReq(uartReadReq), .ram1Addr(ram1AddrW),
        .ram2Addr(ram2AddrW), .ram1Wdata(ram1Wdata), .ram2Wdata(ram2Wdata),
        .txData(txData)
    );

    sramPort uRam1 (
        .clk(clk), .rst(rst), .start(ram1Start), .write(ram1Write),
        .addr(ram1AddrW), .wdata(ram1Wdata), .busIn(ram1Data), .done(ram1Done),
        .rdata(ram1Rdata), .sramAddr(ram1Addr), .sramEN(ram1EN), .sramOE(ram1OeInt),
        .sramWE(ram1WE), .busOut(ram1Out), .busDrive(ram1Drive)
    );

    sramPort uRam2 (
        .clk(clk), .rst(rst), .start(ram2Start), .write(ram2Write),
        .addr(ram2AddrW), .wdata(ram2Wdata), .busIn(ram2Data), .done(ram2Done),
        .rdata(ram2Rdata), .sramAddr(ram2Addr), .sramEN(ram2EN), .sramOE(ram2OE),
        .sramWE(ram2WE), .busOut(ram2Out), .busDrive(ram2Drive)
    );

    txFifo uTxFifo (
        .clk(clk), .rst(rst), .push(txPush), .pop(txPop), .pushData(txData),
        .popData(txHead), .full(txFull), .notEmpty(txNotEmpty)
    );

    uartPort uUart (
        .clk(clk), .rst(rst), .readReq(uartReadReq), .notEmpty(txNotEmpty),
        .tbre(tbre), .tsre(tsre), .dataReady(dataReady), .popData(txHead),
        .busIn(ram1Data), .readDone(uartReadDone), .rxByte(rxByte), .pop(txPop),
        .rdn(rdn), .wrn(wrn), .busOut(uartOut), .busDrive(uartDrive)
    );

    ////////////////////////////////////////////////////////////
    // Shared bus joins
    ////////////////////////////////////////////////////////////

    // Ram1 output stays off whenever the UART chip or port uses the bus
    assign ram1OE = ram1OeInt || !rdn || uartDrive;

    assign ram1Data = uartDrive ? uartOut : 16'bz;
    assign ram1Data = ram1Drive ? ram1Out : 16'bz;
    assign ram2Data = ram2Drive ? ram2Out : 16'bz;

endmodule

// File: bench/boardModels.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Asynchronous SRAM, lower 64K words populated
////////////////////////////////////////////////////////////

module sramModel #(
    parameter logic [15:0] FILL_KEY = 16'h0000
) (
    input  logic              clk,
    input  busPkg::sramAddr_t addr,
    inout  wire [15:0]        data,
    input  logic              en,
    input  logic              oe,
    input  logic              we
);
    logic [15:0] mem [0:65535];
    logic [16:0] fillAddr;

    // Every word differs with its full address
    initial begin
        for (fillAddr = 17'h0; fillAddr < 17'h10000; fillAddr = fillAddr + 17'h1) begin
            mem[fillAddr[15:0]] = fillAddr[15:0] ^ {fillAddr[7:0], fillAddr[15:8]} ^ FILL_KEY;
        end
    end

    assign data = (!en && !oe) ? mem[addr[15:0]] : 16'bz;

    // Strobes are sampled mid-cycle, well clear of the controller edges
    always @(negedge clk) begin
        if (!en && !we) begin
            mem[addr[15:0]] <= data;
        end
    end

endmodule

////////////////////////////////////////////////////////////
// Byte-wide UART chip on the Ram1 data lanes
////////////////////////////////////////////////////////////

module uartModel #(
    parameter int TBRE_CYCLES = 10,
    parameter int TSRE_CYCLES = 5,
    parameter int RX_CYCLES   = 6
) (
    input  logic       clk,
    inout  wire [15:0] data,
    input  logic       rdn,
    input  logic       wrn,
    input  logic       rxLoad,
    input  logic [7:0] rxValue,
    output logic       dataReady,
    output logic       tbre,
    output logic       tsre
);
    logic [7:0] sent [0:15];
    int         sentCount = 0;
    int         txTimer   = 0;
    int         rxTimer   = 0;
    logic       rxArmed   = 1'b0;
    logic [7:0] rxHold    = 8'h00;
    logic       readyReg  = 1'b0;
    logic       tbreReg   = 1'b1;
    logic       tsreReg   = 1'b1;

    // Upper lanes float high on the board
    assign data      = !rdn ? {8'hFF, rxHold} : 16'bz;
    assign dataReady = readyReg;
    assign tbre      = tbreReg;
    assign tsre      = tsreReg;

    // Transmit side, one byte per wrn strobe
    always @(negedge clk) begin
        if (!wrn) begin
            if (sentCount < 16) begin
                sent[sentCount] <= data[7:0];
            end
            sentCount <= sentCount + 1;
            tbreReg   <= 1'b0;
            tsreReg   <= 1'b0;
            txTimer   <= 0;
        end else if (!tsreReg) begin
            txTimer <= txTimer + 1;
            if (txTimer == TBRE_CYCLES) begin
                tbreReg <= 1'b1;
            end
            if (txTimer == TBRE_CYCLES + TSRE_CYCLES) begin
                tsreReg <= 1'b1;
            end
        end
    end

    // Receive side, byte arrives some cycles after a load
    always @(negedge clk) begin
        if (rxLoad) begin
            rxHold  <= rxValue;
            rxArmed <= 1'b1;
            rxTimer <= 0;
        end else if (rxArmed) begin
            rxTimer <= rxTimer + 1;
            if (rxTimer == RX_CYCLES) begin
                readyReg <= 1'b1;
                rxArmed  <= 1'b0;
            end
        end
        // Reading the data register clears the flag
        if (!rdn) begin
            readyReg <= 1'b0;
        end
    end

endmodule

// File: bench/memTb.sv
`timescale 1ns/1ps

module memTb;
    import busPkg::*;
    import memMapPkg::*;

    typedef enum logic [1:0] {
        opWrite,
        opRead,
        opDrain,
        opLoadRx
    } opKind_t;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_ENTRIES  = 18;
    localparam int          CYCLE_LIMIT  = 40 * NUM_ENTRIES + 200;
    localparam logic [31:0] RANDOM_SEED  = 32'hea2;
    localparam word_t       PC_FETCH     = 16'h0040;

    logic       clk = 1'b0;
    logic       rst;
    word_t      pc;
    word_t      address;
    word_t      writeData;
    logic       memRead;
    logic       memWrite;
    logic       rxLoad;
    logic [7:0] rxValue;
    wire        dataReady;
    wire        tbre;
    wire        tsre;
    wire [15:0] ram1Data;
    wire [15:0] ram2Data;
    logic       stall;
    logic       memConflict;
    word_t      readData;
    word_t      instruct;
    sramAddr_t  ram1Addr;
    sramAddr_t  ram2Addr;
    logic       ram1EN;
    logic       ram1OE;
    logic       ram1WE;
    logic       ram2EN;
    logic       ram2OE;
    logic       ram2WE;
    logic       rdn;
    logic       wrn;

    // Stimulus table
    opKind_t    opKind     [NUM_ENTRIES];
    word_t      opAddr     [NUM_ENTRIES];
    word_t      opData     [NUM_ENTRIES];
    word_t      opExpRead  [NUM_ENTRIES];
    logic       opConflict [NUM_ENTRIES];
    logic [7:0] sentBytes  [$];
    int         cycleCount = 0;
    logic [31:0] seedEcho;

    always #(CLK_PERIOD / 2) clk = ~clk;

    memorySubsystem u_memorySubsystem (
        .clk(clk), .rst(rst), .pc(pc), .address(address), .writeData(writeData),
        .memRead(memRead), .memWrite(memWrite), .dataReady(dataReady),
        .tbre(tbre), .tsre(tsre), .stall(stall), .memConflict(memConflict),
        .readData(readData), .instruct(instruct), .ram1Addr(ram1Addr),
        .ram1EN(ram1EN), .ram1OE(ram1OE), .ram1WE(ram1WE), .ram2Addr(ram2Addr),
        .ram2EN(ram2EN), .ram2OE(ram2OE), .ram2WE(ram2WE), .rdn(rdn), .wrn(wrn),
        .ram1Data(ram1Data), .ram2Data(ram2Data)
    );

    sramModel #(.FILL_KEY(16'h5A00)) uRam1Model (
        .clk(clk), .addr(ram1Addr), .data(ram1Data),
        .en(ram1EN), .oe(ram1OE), .we(ram1WE)
    );

    sramModel #(.FILL_KEY(16'h00C3)) uRam2Model (
        .clk(clk), .addr(ram2Addr), .data(ram2Data),
        .en(ram2EN), .oe(ram2OE), .we(ram2WE)
    );

    uartModel uUartModel (
        .clk(clk), .data(ram1Data), .rdn(rdn), .wrn(wrn), .rxLoad(rxLoad),
        .rxValue(rxValue), .dataReady(dataReady), .tbre(tbre), .tsre(tsre)
    );

    ////////////////////////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkWord(input string sigName, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] %s got %h expected %h", sigName, actual, expected));
        end
    endtask

    task automatic checkByte(input string sigName, input logic [7:0] actual,
                             input logic [7:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] %s got %h expected %h", sigName, actual, expected));
        end
    endtask

    task automatic checkFlag(input string sigName, input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] %s got %h expected %h", sigName, actual, expected));
        end
    endtask

    // Cycle budget scales with the table length
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            failRun($sformatf("Timeout reached after %0d cycles", cycleCount));
        end
    end

    ////////////////////////////////////////////////////////////
    // Table construction
    ////////////////////////////////////////////////////////////

    function automatic word_t randomWord();
        logic [31:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    function automatic word_t pickRam2Addr(input word_t avoid);
        word_t a;
        a = randomWord() | 16'h8000;
        while (a == COM1_DATA || a == COM1_COMMAND || a == avoid) begin
            a = randomWord() | 16'h8000;
        end
        return a;
    endfunction

    function automatic word_t pickRam1Addr();
        word_t a;
        a = randomWord() & (RAM1_UPPER - 16'h1);
        while (a == PC_FETCH) begin
            a = randomWord() & (RAM1_UPPER - 16'h1);
        end
        return a;
    endfunction

    // Queue not full in bit0 and receive data ready in bit1
    function automatic word_t statusWord(input logic notFull, input logic ready);
        return {14'b0, ready, notFull};
    endfunction

    task automatic setEntry(input int idx, input opKind_t kind, input word_t addr,
                            input word_t data, input word_t expRead, input logic conflict);
        opKind[idx]     = kind;
        opAddr[idx]     = addr;
        opData[idx]     = data;
        opExpRead[idx]  = expRead;
        opConflict[idx] = conflict;
    endtask

    task automatic buildTable();
        word_t      ram2A;
        word_t      ram2B;
        word_t      ram1A;
        word_t      dataA;
        word_t      dataB;
        word_t      dataC;
        word_t      rxWord;
        logic [7:0] rxPick;
        int         k;
        ram2A  = pickRam2Addr(COM1_DATA);
        ram2B  = pickRam2Addr(ram2A);
        ram1A  = pickRam1Addr();
        dataA  = randomWord();
        dataB  = randomWord();
        dataC  = randomWord();
        rxWord = randomWord();
        rxPick = rxWord[7:0];
        setEntry(0, opWrite, ram2A, dataA, 16'h0, 1'b0);
        setEntry(1, opWrite, ram2B, dataB, 16'h0, 1'b0);
        setEntry(2, opRead, ram2A, 16'h0, dataA, 1'b0);
        setEntry(3, opRead, ram2B, 16'h0, dataB, 1'b0);
        setEntry(4, opWrite, ram1A, dataC, 16'h0, 1'b1);
        setEntry(5, opRead, ram1A, 16'h0, dataC, 1'b1);
        // Four bytes fill the queue while the chip is still busy
        for (k = 0; k < 4; k++) begin
            setEntry(6 + k, opWrite, COM1_DATA, randomWord(), 16'h0, 1'b1);
        end
        setEntry(10, opRead, COM1_COMMAND, 16'h0, statusWord(1'b0, 1'b0), 1'b1);
        setEntry(11, opWrite, COM1_DATA, randomWord(), 16'h0, 1'b1);
        setEntry(12, opDrain, 16'h0, 16'h0, 16'h0, 1'b0);
        setEntry(13, opRead, COM1_COMMAND, 16'h0, statusWord(1'b1, 1'b0), 1'b1);
        setEntry(14, opLoadRx, 16'h0, {8'h00, rxPick}, 16'h0, 1'b0);
        setEntry(15, opRead, COM1_COMMAND, 16'h0, statusWord(1'b1, 1'b1), 1'b1);
        setEntry(16, opRead, COM1_DATA, 16'h0, {8'h00, rxPick}, 1'b1);
        setEntry(17, opRead, COM1_COMMAND, 16'h0, statusWord(1'b1, 1'b0), 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // Entry execution
    ////////////////////////////////////////////////////////////

    task automatic checkHeld(input word_t expInstr, input logic expConflict);
        checkFlag("memConflict", memConflict, expConflict);
        checkWord("instruct", instruct, expInstr);
    endtask

    task automatic runAccess(input int idx);
        word_t expInstr;
        logic  isRead;
        isRead    = (opKind[idx] == opRead);
        address   = opAddr[idx];
        writeData = opData[idx];
        memRead   = isRead;
        memWrite  = !isRead;
        if (!isRead && opAddr[idx] == COM1_DATA) begin
            sentBytes.push_back(opData[idx][7:0]);
        end
        #1;
        expInstr = opConflict[idx] ? NOP_INSTRUCT : uRam1Model.mem[PC_FETCH];
        checkHeld(expInstr, opConflict[idx]);
        while (stall) begin
            @(negedge clk);
            #1;
            checkHeld(expInstr, opConflict[idx]);
        end
        // The rising edge ahead completes the access
        @(negedge clk);
        memRead  = 1'b0;
        memWrite = 1'b0;
        #1;
        if (isRead) begin
            checkWord("readData", readData, opExpRead[idx]);
        end
        @(negedge clk);
    endtask

    task automatic waitForBytes();
        int n;
        while (uUartModel.sentCount < sentBytes.size()) begin
            @(negedge clk);
            #1;
        end
        if (uUartModel.sentCount > sentBytes.size()) begin
            failRun("UART model received more bytes than were written");
        end
        for (n = 0; n < sentBytes.size(); n++) begin
            checkByte($sformatf("uart byte %0d", n), uUartModel.sent[n], sentBytes[n]);
        end
        @(negedge clk);
    endtask

    // Hands a receive byte to the UART model and waits for dataReady
    task automatic loadRxByte(input logic [7:0] value);
        @(posedge clk);
        rxValue = value;
        rxLoad  = 1'b1;
        @(posedge clk);
        rxLoad = 1'b0;
        do begin
            @(negedge clk);
            #1;
        end while (!dataReady);
        @(negedge clk);
    endtask

    task automatic applyEntry(input int idx);
        case (opKind[idx])
            opDrain:  waitForBytes();
            opLoadRx: loadRxByte(opData[idx][7:0]);
            default:  runAccess(idx);
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst       = 1'b0;
        pc        = PC_FETCH;
        address   = 16'h0;
        writeData = 16'h0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        rxLoad    = 1'b0;
        rxValue   = 8'h00;
        seedEcho  = $urandom(RANDOM_SEED);

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        #1;
        // Idle state before the first active edge
        checkFlag("stall", stall, 1'b0);
        checkFlag("memConflict", memConflict, 1'b0);
        checkFlag("rdn", rdn, 1'b1);
        checkFlag("wrn", wrn, 1'b1);
        checkFlag("ram1EN", ram1EN, 1'b1);
        checkFlag("ram1OE", ram1OE, 1'b1);
        checkFlag("ram1WE", ram1WE, 1'b1);
        checkFlag("ram2EN", ram2EN, 1'b1);
        checkFlag("ram2OE", ram2OE, 1'b1);
        checkFlag("ram2WE", ram2WE, 1'b1);
        checkWord("instruct", instruct, NOP_INSTRUCT);

        // Let the first fetch land
        repeat (4) @(negedge clk);
        buildTable();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            applyEntry(i);
        end

        repeat (2) @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: sim.f
verilog/memMapPkg.sv
verilog/busPkg.sv
verilog/memArbiter.sv
verilog/sramPort.sv
verilog/txFifo.sv
verilog/uartPort.sv
verilog/memorySubsystem.sv
bench/boardModels.sv
bench/memTb.sv

// File: Bender.yml
package:
  name: memsubsystem

sources:
  - files:
      - verilog/memMapPkg.sv
      - verilog/busPkg.sv
      - verilog/memArbiter.sv
      - verilog/sramPort.sv
      - verilog/txFifo.sv
      - verilog/uartPort.sv
      - verilog/memorySubsystem.sv
  - target: simulation
    files:
      - bench/boardModels.sv
      - bench/memTb.sv
